//--- design/phaethon_cfg.svh
`ifndef PHAETHON_CFG_SVH
`define PHAETHON_CFG_SVH

// Datapath width, also the address width
`define PH_WORD_W 32

// Register space. Fixed regs sit below the window
`define PH_FIXED_REGS 4
`define PH_WINDOW_REGS 64
`define PH_REG_COUNT (`PH_FIXED_REGS + `PH_WINDOW_REGS)
`define PH_FIELD_FIXED 64         // Field value where fixed regs start

// Fixed register roles
`define PH_SP_REG 0
`define PH_FLAGS_REG 1

// Byte steps
`define PH_STACK_STEP 4           // One stack slot
`define PH_INSTR_STEP 4           // One instruction word

`endif

//--- design/phaethonPkg.sv
`default_nettype none

`include "phaethon_cfg.svh"

package phaethonPkg;

  typedef logic [`PH_WORD_W-1:0] word_t;
  typedef logic [$clog2(`PH_REG_COUNT)-1:0] regIdx_t;   // Physical register index

  // Byte 0 of the instruction word
  typedef enum logic [7:0] {
    opStall     = 8'h00,
    opDoutR     = 8'h01,
    opMovRC     = 8'h02,
    opMovRR     = 8'h03,
    opAddRRC    = 8'h04,
    opAddRRR    = 8'h05,
    opSubRRC    = 8'h06,
    opSubRRR    = 8'h07,
    opIncR      = 8'h08,
    opDecR      = 8'h09,
    opShlRRR    = 8'h0a,
    opShrRRR    = 8'h0b,
    opNegRR     = 8'h0c,
    opMulAddRRC = 8'h0d,
    opPackRRR   = 8'h0e,
    opMovRdC    = 8'h10,   // Loads and stores
    opMovRdRo   = 8'h11,
    opMovRdR    = 8'h12,
    opMovdCR    = 8'h13,
    opMovdRoR   = 8'h14,
    opPushR     = 8'h15,   // Stack
    opPopR      = 8'h16,
    opCallR     = 8'h17,
    opRet       = 8'h18,
    opCmpRR     = 8'h20,   // Compares
    opCmpRC     = 8'h21,
    opCmpERRR   = 8'h22,
    opCmpLtRRR  = 8'h23,
    opJmpC      = 8'h28,   // Jumps
    opJeC       = 8'h29,
    opJneC      = 8'h2a,
    opJzRC      = 8'h2b,
    opJnzRC     = 8'h2c
  } opcode_e;

  typedef struct packed {
    logic gt;
    logic lt;
    logic eq;               // Bit 0, tested by JeC and JneC
  } flags_t;

  typedef struct packed {
    opcode_e opcode;
    logic    hasConst;      // 8-byte form
    logic    memRead;
    logic    memWrite;
    logic    writesReg;
    logic    flowChange;    // Next ip not simply sequential
    regIdx_t dst;
    regIdx_t srcB;
    regIdx_t srcC;
  } decoded_t;

  typedef struct packed {
    word_t valA;
    word_t valB;
    word_t valC;
    word_t dataWord;        // Constant from second instruction word
  } operands_t;

  typedef struct packed {
    logic    regWe;
    regIdx_t regAddr;
    word_t   regData;
    logic    flagsWe;
    flags_t  flags;
    logic    spWe;
    word_t   spData;
    word_t   nextIp;
  } result_t;

  typedef struct packed {
    logic  rd;
    logic  wr;
    word_t addr;            // Byte address
    word_t wdata;
  } memReq_t;

endpackage

`default_nettype wire

//--- design/instrDecode.sv
`timescale 1ns/1ps
`default_nettype none

`include "phaethon_cfg.svh"

module instrDecode (
  input  logic                  clk,
  input  logic                  reset,
  input  phaethonPkg::word_t    instrWord,
  input  logic                  decodeEn,
  output phaethonPkg::decoded_t dec
);
  import phaethonPkg::*;

  opcode_e opcode;
  logic    hasConst;
  logic    memRead;
  logic    memWrite;
  logic    writesReg;
  logic    flowChange;

  // Field at or above 64 hits a fixed reg, else the window at base 4
  function automatic regIdx_t mapField(input logic [7:0] field);
    logic [7:0] phys;
    if (field >= 8'(`PH_FIELD_FIXED)) begin
      phys = field - 8'(`PH_FIELD_FIXED);
    end else begin
      phys = field + 8'(`PH_FIXED_REGS);
    end
    return regIdx_t'(phys);
  endfunction

  // Opcode class table
  always_comb begin
    opcode     = opcode_e'(instrWord[7:0]);
    hasConst   = 1'b0;
    memRead    = 1'b0;
    memWrite   = 1'b0;
    writesReg  = 1'b0;
    flowChange = 1'b0;
    case (opcode)
      opMovRC, opAddRRC, opSubRRC, opMulAddRRC: begin
        hasConst  = 1'b1;
        writesReg = 1'b1;
      end
      opMovRR, opAddRRR, opSubRRR, opIncR, opDecR, opShlRRR, opShrRRR, opNegRR,
      opPackRRR, opCmpERRR, opCmpLtRRR: writesReg = 1'b1;
      opMovRdC, opMovRdRo: begin      // Load, address from constant
        hasConst  = 1'b1;
        memRead   = 1'b1;
        writesReg = 1'b1;
      end
      opMovRdR, opPopR: begin
        memRead   = 1'b1;
        writesReg = 1'b1;
      end
      opMovdCR, opMovdRoR: begin
        hasConst = 1'b1;
        memWrite = 1'b1;
      end
      opPushR: memWrite = 1'b1;
      opCallR: begin                  // Pushes ip
        memWrite   = 1'b1;
        flowChange = 1'b1;
      end
      opRet: begin                    // Pops return ip
        memRead    = 1'b1;
        flowChange = 1'b1;
      end
      opCmpRC: hasConst = 1'b1;
      opJmpC, opJeC, opJneC, opJzRC, opJnzRC: begin
        hasConst   = 1'b1;            // Target in constant
        flowChange = 1'b1;
      end
      opStall: flowChange = 1'b1;
      default: ;                      // CmpRR, DoutR
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dec <= '0;                      // Decodes as Stall
    end else if (decodeEn) begin
      dec.opcode     <= opcode;
      dec.hasConst   <= hasConst;
      dec.memRead    <= memRead;
      dec.memWrite   <= memWrite;
      dec.writesReg  <= writesReg;
      dec.flowChange <= flowChange;
      dec.dst        <= mapField(instrWord[15:8]);
      dec.srcB       <= mapField(instrWord[23:16]);
      dec.srcC       <= mapField(instrWord[31:24]);
    end
  end

endmodule

`default_nettype wire

//--- design/executeUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "phaethon_cfg.svh"

module executeUnit (
  input  phaethonPkg::decoded_t  dec,
  input  phaethonPkg::operands_t ops,
  input  phaethonPkg::flags_t    flags,
  input  phaethonPkg::word_t     stackPtr,
  input  phaethonPkg::word_t     ip,
  input  phaethonPkg::word_t     loadValue,
  output phaethonPkg::result_t   res,
  output phaethonPkg::memReq_t   memReq,
  output logic                   doutValid,
  output phaethonPkg::word_t     doutData
);
  import phaethonPkg::*;

  localparam word_t StackStep = word_t'(`PH_STACK_STEP);
  localparam word_t InstrStep = word_t'(`PH_INSTR_STEP);

  word_t  aluOut;
  word_t  packWord;
  word_t  cmpRhs;
  flags_t cmpFlags;
  logic   jumpTaken;
  word_t  seqIp;
  word_t  flowIp;

  // PackRRR drops one byte of valB into valA
  always_comb begin
    packWord = ops.valA;
    packWord[ops.valC[1:0]*8 +: 8] = ops.valB[7:0];
  end

  assign cmpRhs       = (dec.opcode == opCmpRC) ? ops.dataWord : ops.valB;
  assign cmpFlags.eq  = ops.valA == cmpRhs;
  assign cmpFlags.lt  = ops.valA < cmpRhs;      // Unsigned compare
  assign cmpFlags.gt  = ops.valA > cmpRhs;

  always_comb begin
    case (dec.opcode)
      opMovRC:     aluOut = ops.dataWord;
      opMovRR:     aluOut = ops.valB;
      opAddRRC:    aluOut = ops.valB + ops.dataWord;
      opAddRRR:    aluOut = ops.valB + ops.valC;
      opSubRRC:    aluOut = ops.valB - ops.dataWord;
      opSubRRR:    aluOut = ops.valB - ops.valC;
      opIncR:      aluOut = ops.valA + word_t'(1);
      opDecR:      aluOut = ops.valA - word_t'(1);
      opShlRRR:    aluOut = ops.valB << ops.valC;
      opShrRRR:    aluOut = ops.valB >> ops.valC;
      opNegRR:     aluOut = -ops.valB;
      opMulAddRRC: aluOut = ops.valA + ops.valB * ops.dataWord;
      opPackRRR:   aluOut = packWord;
      opCmpERRR:   aluOut = word_t'(ops.valB == ops.valC);
      opCmpLtRRR:  aluOut = word_t'(ops.valB < ops.valC);
      default:     aluOut = loadValue;             // Loads and pop
    endcase
  end

  always_comb begin
    memReq.rd    = dec.memRead;
    memReq.wr    = dec.memWrite;
    memReq.wdata = ops.valB;
    case (dec.opcode)
      opMovRdC, opMovdCR: memReq.addr = ops.dataWord;
      opMovRdRo:          memReq.addr = ops.dataWord + ops.valB;
      opMovdRoR:          memReq.addr = ops.dataWord + ops.valA;
      opMovRdR:           memReq.addr = ops.valB;
      opPopR, opRet:      memReq.addr = stackPtr - StackStep;  // Top slot
      default:            memReq.addr = stackPtr;              // Push, call
    endcase
    if (dec.opcode == opPushR) memReq.wdata = ops.valA;
    if (dec.opcode == opCallR) memReq.wdata = ip;              // Ret adds 4 later
  end

  // Flow changes go ahead unless a conditional jump fails
  always_comb begin
    case (dec.opcode)
      opJeC:   jumpTaken = flags.eq;
      opJneC:  jumpTaken = !flags.eq;
      opJzRC:  jumpTaken = ops.valA == '0;
      opJnzRC: jumpTaken = ops.valA != '0;
      default: jumpTaken = 1'b1;                   // JmpC, call, ret and Stall
    endcase
  end

  assign seqIp = ip + (dec.hasConst ? InstrStep * 2 : InstrStep);

  always_comb begin
    case (dec.opcode)
      opCallR: flowIp = ops.valA;
      opRet:   flowIp = loadValue + InstrStep;     // Skip the call itself
      opStall: flowIp = ip;                        // Spin here
      default: flowIp = ops.dataWord;              // Jump target
    endcase
  end

  always_comb begin
    res.regWe   = dec.writesReg;
    res.regAddr = dec.dst;
    res.regData = aluOut;
    res.flagsWe = 1'b0;
    res.flags   = cmpFlags;
    res.spWe    = 1'b0;
    res.spData  = stackPtr + StackStep;            // Stack grows upward
    res.nextIp  = (dec.flowChange && jumpTaken) ? flowIp : seqIp;
    case (dec.opcode)
      opCmpRR, opCmpRC: res.flagsWe = 1'b1;
      opPushR, opCallR: res.spWe = 1'b1;
      opPopR, opRet: begin
        res.spWe   = 1'b1;
        res.spData = stackPtr - StackStep;
      end
      default: ;
    endcase
  end

  assign doutValid = dec.opcode == opDoutR;        // Gated by commit at top
  assign doutData  = ops.valA;

endmodule

`default_nettype wire

//--- design/regWriteBack.sv
`timescale 1ns/1ps
`default_nettype none

`include "phaethon_cfg.svh"

module regWriteBack (
  input  logic                   clk,
  input  logic                   reset,
  input  phaethonPkg::decoded_t  dec,
  input  logic                   operandEn,
  input  phaethonPkg::word_t     dataWord,
  input  logic                   commitEn,
  input  phaethonPkg::result_t   res,
  output phaethonPkg::operands_t ops,
  output phaethonPkg::flags_t    flags,
  output phaethonPkg::word_t     stackPtr
);
  import phaethonPkg::*;

  // SP and flags live in their own flops, the array holds the rest
  localparam int FirstArrayReg = `PH_FLAGS_REG + 1;
  localparam int LastReg       = `PH_REG_COUNT - 1;

  word_t regFile [FirstArrayReg:LastReg];
  word_t valA;
  word_t valB;
  word_t valC;
  logic  arrayWe;

  // Unmapped indices read as zero
  function automatic word_t readReg(input regIdx_t idx);
    if (idx == regIdx_t'(`PH_SP_REG)) begin
      return stackPtr;
    end else if (idx == regIdx_t'(`PH_FLAGS_REG)) begin
      return word_t'(flags);
    end else if (int'(idx) <= LastReg) begin
      return regFile[idx];
    end
    return '0;
  endfunction

  assign arrayWe = commitEn && res.regWe && int'(res.regAddr) >= FirstArrayReg &&
                   int'(res.regAddr) <= LastReg;

  always_ff @(posedge clk) begin
    if (arrayWe) begin
      regFile[res.regAddr] <= res.regData;
    end
  end

  // Dedicated writes win over a plain register write
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      stackPtr <= '0;
      flags    <= '0;
    end else if (commitEn) begin
      if (res.regWe && res.regAddr == regIdx_t'(`PH_SP_REG)) stackPtr <= res.regData;
      if (res.spWe) stackPtr <= res.spData;
      if (res.regWe && res.regAddr == regIdx_t'(`PH_FLAGS_REG)) begin
        flags <= flags_t'(res.regData[2:0]);
      end
      if (res.flagsWe) flags <= res.flags;
    end
  end

  // Operand latch, one read per field
  always_ff @(posedge clk) begin
    if (operandEn) begin
      valA <= readReg(dec.dst);
      valB <= readReg(dec.srcB);
      valC <= readReg(dec.srcC);
    end
  end

  // Constant comes straight from the sequencer
  assign ops = '{valA: valA, valB: valB, valC: valC, dataWord: dataWord};

endmodule

`default_nettype wire

//--- design/coreSequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "phaethon_cfg.svh"

module coreSequencer (
  input  logic                  clk,
  input  logic                  reset,
  input  phaethonPkg::word_t    ramIn,
  input  phaethonPkg::decoded_t dec,
  input  phaethonPkg::memReq_t  memReq,
  input  phaethonPkg::word_t    nextIp,
  output phaethonPkg::word_t    ramAddress,
  output phaethonPkg::word_t    ramOut,
  output logic                  readReq,
  output logic                  writeReq,
  output logic                  decodeEn,
  output logic                  operandEn,
  output logic                  commitEn,
  output phaethonPkg::word_t    ip,
  output phaethonPkg::word_t    dataWord,
  output phaethonPkg::word_t    loadValue
);
  import phaethonPkg::*;

  typedef enum logic [3:0] {
    Fetch,
    FetchWait,      // RAM latches address
    Decode,         // Instruction word on ramIn
    OperandRead,
    ConstWait,
    ConstDone,      // Constant on ramIn
    MemRequest,
    MemWait,
    MemDone,        // Load data on ramIn
    Commit
  } mode_e;

  mode_e mode;
  logic  memAccess;

  assign memAccess = dec.memRead | dec.memWrite;

  // One-cycle stage strobes
  assign decodeEn  = mode == Decode;
  assign operandEn = mode == OperandRead;
  assign commitEn  = mode == Commit;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mode     <= Fetch;
      ip       <= '0;
      readReq  <= 1'b0;
      writeReq <= 1'b0;
    end else begin
      readReq  <= 1'b0;                   // Strobes drop by default
      writeReq <= 1'b0;
      case (mode)
        Fetch: begin
          readReq <= 1'b1;
          mode    <= FetchWait;
        end
        FetchWait: mode <= Decode;
        Decode:    mode <= OperandRead;
        OperandRead: begin
          if (dec.hasConst) begin
            readReq <= 1'b1;              // Second instruction word
            mode    <= ConstWait;
          end else if (memAccess) begin
            mode <= MemRequest;
          end else begin
            mode <= Commit;
          end
        end
        ConstWait: mode <= ConstDone;
        ConstDone: mode <= memAccess ? MemRequest : Commit;
        MemRequest: begin
          readReq  <= memReq.rd;
          writeReq <= memReq.wr;
          mode     <= MemWait;
        end
        MemWait: mode <= MemDone;
        MemDone: mode <= Commit;
        Commit: begin
          ip   <= nextIp;
          mode <= Fetch;
        end
        default: mode <= Fetch;
      endcase
    end
  end

  // Address, store data and captured words
  always_ff @(posedge clk) begin
    case (mode)
      Fetch:       ramAddress <= ip;
      OperandRead: ramAddress <= ip + word_t'(`PH_INSTR_STEP);
      ConstDone:   dataWord   <= ramIn;
      MemRequest: begin
        ramAddress <= memReq.addr;
        ramOut     <= memReq.wdata;
      end
      MemDone:     loadValue  <= ramIn;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- design/phaethonCore.sv
`timescale 1ns/1ps
`default_nettype none

module phaethonCore (
  input  logic               clk,
  input  logic               reset,
  input  phaethonPkg::word_t ramIn,
  output phaethonPkg::word_t ramAddress,
  output phaethonPkg::word_t ramOut,
  output logic               readReq,
  output logic               writeReq,
  output logic               doutValid,
  output phaethonPkg::word_t doutData
);
  import phaethonPkg::*;

  decoded_t  dec;
  operands_t ops;
  flags_t    flags;
  word_t     stackPtr;
  word_t     ip;
  word_t     dataWord;
  word_t     loadValue;
  result_t   res;
  memReq_t   memReq;
  logic      decodeEn;
  logic      operandEn;
  logic      commitEn;
  logic      execDout;

  instrDecode decode_i (
    .clk, .reset, .instrWord(ramIn), .decodeEn, .dec
  );

  regWriteBack regs_i (
    .clk, .reset, .dec, .operandEn, .dataWord, .commitEn, .res, .ops, .flags, .stackPtr
  );

  executeUnit exec_i (
    .dec, .ops, .flags, .stackPtr, .ip, .loadValue, .res, .memReq,
    .doutValid(execDout), .doutData
  );

  coreSequencer seq_i (
    .clk, .reset, .ramIn, .dec, .memReq, .nextIp(res.nextIp), .ramAddress, .ramOut,
    .readReq, .writeReq, .decodeEn, .operandEn, .commitEn, .ip, .dataWord, .loadValue
  );

  assign doutValid = execDout & commitEn;   // Single pulse in Commit

endmodule

`default_nettype wire

//--- tb/phaethonModel.svh
`ifndef PHAETHON_MODEL_SVH
`define PHAETHON_MODEL_SVH

// Program builder, 4-byte form
task automatic emitOp(input opcode_e op, input int a, input int b, input int c);
  prog[progLen] = {8'(c), 8'(b), 8'(a), op};
  progLen++;
endtask

// 8-byte form, constant in the second word
task automatic emitConst(input opcode_e op, input int a, input int b, input int c,
                         input word_t k);
  emitOp(op, a, b, c);
  prog[progLen] = k;
  progLen++;
endtask

// Point a constant slot at the next free address
task automatic patchHere(input int slot);
  prog[slot] = word_t'(progLen * 4);
endtask

// Register field to physical index, window base 4
function automatic int regPhys(input logic [7:0] field);
  return (field >= 8'd64) ? int'(field) - 64 : int'(field) + 4;
endfunction

// Instruction-set model, runs on modelMem until Stall
function automatic int runModel(input int maxSteps);
  word_t   r [0:67];
  word_t   ip, instr, k, a, b, c, wv, next, sp, newSp, x;
  int      d, sb, sc, steps, lat, i;
  longint  cyc;
  logic    hasK, isMem, stop, we;
  opcode_e op;
  for (i = 0; i < 68; i++) r[i] = '0;
  ip = '0;
  steps = 0;
  cyc = 0;
  stop = 1'b0;
  while (!stop && steps < maxSteps) begin
    instr = modelMem[ip[11:2]];
    k     = modelMem[ip[11:2] + 10'd1];
    op    = opcode_e'(instr[7:0]);
    d     = regPhys(instr[15:8]);
    sb    = regPhys(instr[23:16]);
    sc    = regPhys(instr[31:24]);
    a     = (d < 68) ? r[d] : '0;       // Out-of-range reads as zero
    b     = (sb < 68) ? r[sb] : '0;
    c     = (sc < 68) ? r[sc] : '0;
    sp    = r[0];
    newSp = sp;
    we    = 1'b0;
    wv    = '0;
    hasK  = op inside {opMovRC, opAddRRC, opSubRRC, opMulAddRRC, opMovRdC, opMovRdRo,
                       opMovdCR, opMovdRoR, opCmpRC, opJmpC, opJeC, opJneC, opJzRC,
                       opJnzRC};
    isMem = op inside {opMovRdC, opMovRdRo, opMovRdR, opMovdCR, opMovdRoR, opPushR,
                       opPopR, opCallR, opRet};
    lat   = 5 + (hasK ? 2 : 0) + (isMem ? 3 : 0);
    next  = ip + (hasK ? 32'd8 : 32'd4);
    case (op)
      opMovRC:     begin we = 1'b1; wv = k; end
      opMovRR:     begin we = 1'b1; wv = b; end
      opAddRRC:    begin we = 1'b1; wv = b + k; end
      opAddRRR:    begin we = 1'b1; wv = b + c; end
      opSubRRC:    begin we = 1'b1; wv = b - k; end
      opSubRRR:    begin we = 1'b1; wv = b - c; end
      opIncR:      begin we = 1'b1; wv = a + 1; end
      opDecR:      begin we = 1'b1; wv = a - 1; end
      opShlRRR:    begin we = 1'b1; wv = b << c; end
      opShrRRR:    begin we = 1'b1; wv = b >> c; end
      opNegRR:     begin we = 1'b1; wv = 32'd0 - b; end
      opMulAddRRC: begin we = 1'b1; wv = a + b * k; end
      opPackRRR: begin                     // Byte lane from c[1:0]
        we = 1'b1;
        wv = (a & ~(32'hff << (8 * c[1:0]))) | ({24'd0, b[7:0]} << (8 * c[1:0]));
      end
      opCmpERRR:   begin we = 1'b1; wv = {31'd0, b == c}; end
      opCmpLtRRR:  begin we = 1'b1; wv = {31'd0, b < c}; end
      opMovRdC:    begin we = 1'b1; wv = modelMem[k[11:2]]; end
      opMovRdRo: begin
        x  = k + b;
        we = 1'b1;
        wv = modelMem[x[11:2]];
      end
      opMovRdR:    begin we = 1'b1; wv = modelMem[b[11:2]]; end
      opMovdCR:    modelMem[k[11:2]] = b;
      opMovdRoR: begin
        x = k + a;
        modelMem[x[11:2]] = b;
      end
      opPushR: begin
        modelMem[sp[11:2]] = a;
        newSp = sp + 4;                    // Grows upward
      end
      opPopR: begin
        x     = sp - 4;
        we    = 1'b1;
        wv    = modelMem[x[11:2]];
        newSp = x;
      end
      opCallR: begin
        modelMem[sp[11:2]] = ip;
        newSp = sp + 4;
        next  = a;
      end
      opRet: begin
        x     = sp - 4;
        next  = modelMem[x[11:2]] + 4;     // Return past the call
        newSp = x;
      end
      opCmpRR:  r[1] = {29'd0, a > b, a < b, a == b};
      opCmpRC:  r[1] = {29'd0, a > k, a < k, a == k};
      opJmpC:   next = k;
      opJeC:    if (r[1][0]) next = k;
      opJneC:   if (!r[1][0]) next = k;
      opJzRC:   if (a == 0) next = k;
      opJnzRC:  if (a != 0) next = k;
      opDoutR: begin
        expDout.push_back(a);
        expStamp.push_back(cyc);
      end
      opStall: begin
        stop = 1'b1;
        next = ip;
      end
      default: ;
    endcase
    if (we) begin
      if (d == 1) r[1] = wv & 32'h7;       // Flags keep 3 bits
      else if (d < 68) r[d] = wv;
    end
    if (newSp != sp) r[0] = newSp;
    cyc += lat;
    ip = next;
    steps++;
  end
  modelStallIp = ip;
  return steps;
endfunction

`endif

//--- tb/phaethonTb.sv
`timescale 1ns/1ps
`default_nettype none

module phaethonTb;
  import phaethonPkg::*;

  logic   clk;
  logic   reset;
  word_t  ramIn;
  word_t  ramAddress;
  word_t  ramOut;
  logic   readReq;
  logic   writeReq;
  logic   doutValid;
  word_t  doutData;

  word_t  prog [0:1023];        // Initial image
  word_t  ramImg [0:1023];      // RAM seen by the DUT
  word_t  modelMem [0:1023];    // RAM after the model run
  int     progLen;
  word_t  expDout [$];
  longint expStamp [$];
  word_t  modelStallIp;
  logic [31:0] lfsrState = 32'h8a5a;
  longint cycleCount = 0;
  longint firstDoutCycle;
  int     doutCount = 0;
  int     stallFetches = 0;
  int     watchCycles;
  logic   modelReady = 1'b0;

  `include "phaethonModel.svh"

  phaethonCore dut_i (
    .clk, .reset, .ramIn, .ramAddress, .ramOut, .readReq, .writeReq, .doutValid, .doutData
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Galois LFSR stepped once per bit
  function automatic logic lfsrBit();
    logic lsb;
    lsb = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (lsb) lfsrState ^= 32'hA3000000;
    return lsb;
  endfunction

  function automatic word_t randBits(input int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], lfsrBit()};
    return v;
  endfunction

  task automatic reportFailure(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic checkDout(input word_t got, input word_t exp);
    if (got !== exp) begin
      reportFailure($sformatf("FAIL at %0t: doutData got %h expected %h", $time, got, exp));
    end
  endtask

  task automatic checkRamWord(input int idx, input word_t got, input word_t exp);
    if (got !== exp) begin
      reportFailure($sformatf("FAIL at %0t: ram[%0d] got %h expected %h",
                              $time, idx, got, exp));
    end
  endtask

  task automatic checkDoutGap(input longint got, input longint exp);
    if (got != exp) begin
      reportFailure($sformatf("FAIL at %0t: doutValid cycle got %0d expected %0d",
                              $time, got, exp));
    end
  endtask

  task automatic buildProgram();
    word_t v;
    int    slot;
    int    callSlot;
    int    loopAddr;
    for (int i = 0; i < 1024; i++) prog[i] = (i * 32'h01000193) ^ 32'h5a5a0000;
    progLen = 0;
    emitConst(opMovRC, 64, 0, 0, 32'hE00);            // SP via fixed reg 0
    // Arithmetic
    emitConst(opMovRC, 1, 0, 0, randBits(32));
    emitConst(opMovRC, 2, 0, 0, randBits(32));
    emitOp(opAddRRR, 3, 1, 2);
    emitOp(opDoutR, 3, 0, 0);
    emitConst(opSubRRC, 4, 3, 0, randBits(32));
    emitOp(opDoutR, 4, 0, 0);
    emitConst(opMovRC, 5, 0, 0, randBits(5));
    emitOp(opShlRRR, 6, 1, 5);
    emitOp(opDoutR, 6, 0, 0);
    emitOp(opShrRRR, 7, 2, 5);
    emitOp(opDoutR, 7, 0, 0);
    emitOp(opNegRR, 8, 1, 0);
    emitOp(opDoutR, 8, 0, 0);
    emitConst(opMulAddRRC, 8, 2, 0, randBits(32));
    emitOp(opDoutR, 8, 0, 0);
    emitConst(opMovRC, 9, 0, 0, randBits(2));
    emitOp(opPackRRR, 8, 1, 9);
    emitOp(opDoutR, 8, 0, 0);
    // Memory
    emitConst(opMovdCR, 0, 1, 0, 32'hA00);
    emitConst(opMovRC, 10, 0, 0, 32'hA10);
    emitConst(opMovdRoR, 10, 2, 0, 32'd4);
    emitConst(opMovRdC, 11, 0, 0, 32'hA00);
    emitOp(opDoutR, 11, 0, 0);
    emitConst(opMovRdRo, 12, 10, 0, 32'd4);
    emitOp(opDoutR, 12, 0, 0);
    emitConst(opMovRC, 13, 0, 0, 32'hA00);
    emitOp(opMovRdR, 14, 13, 0);
    emitOp(opDoutR, 14, 0, 0);
    // Stack with fixed reg 64 as SP
    emitOp(opPushR, 1, 0, 0);
    emitOp(opPushR, 2, 0, 0);
    emitOp(opDoutR, 64, 0, 0);
    emitOp(opPopR, 15, 0, 0);
    emitOp(opDoutR, 15, 0, 0);
    emitOp(opDoutR, 64, 0, 0);
    emitConst(opMovRC, 16, 0, 0, '0);
    callSlot = progLen - 1;
    emitOp(opCallR, 16, 0, 0);
    emitOp(opDoutR, 17, 0, 0);                         // After return
    // Compares and jumps where each skipped marker outputs field 1
    v = randBits(31) | 32'd1;                          // Top bit clear so v + 1 cannot wrap
    emitConst(opMovRC, 18, 0, 0, v);
    emitConst(opMovRC, 19, 0, 0, v);
    emitOp(opCmpRR, 18, 19, 0);
    emitConst(opJeC, 0, 0, 0, '0);
    slot = progLen - 1;
    emitOp(opDoutR, 1, 0, 0);
    patchHere(slot);
    emitConst(opJneC, 0, 0, 0, '0);
    slot = progLen - 1;
    emitOp(opDoutR, 18, 0, 0);
    patchHere(slot);
    emitConst(opCmpRC, 18, 0, 0, v + 1);               // Less
    emitOp(opDoutR, 65, 0, 0);
    emitConst(opJeC, 0, 0, 0, '0);
    slot = progLen - 1;
    emitOp(opDoutR, 19, 0, 0);
    patchHere(slot);
    emitConst(opJneC, 0, 0, 0, '0);
    slot = progLen - 1;
    emitOp(opDoutR, 1, 0, 0);
    patchHere(slot);
    emitConst(opCmpRC, 18, 0, 0, v - 1);               // Greater
    emitOp(opDoutR, 65, 0, 0);
    emitConst(opMovRC, 20, 0, 0, '0);
    emitConst(opJzRC, 20, 0, 0, '0);
    slot = progLen - 1;
    emitOp(opDoutR, 1, 0, 0);
    patchHere(slot);
    emitConst(opJnzRC, 20, 0, 0, '0);
    slot = progLen - 1;
    emitOp(opDoutR, 18, 0, 0);
    patchHere(slot);
    // Timing loop
    emitConst(opMovRC, 21, 0, 0, 32'd3);
    loopAddr = progLen * 4;
    emitOp(opDoutR, 21, 0, 0);
    emitConst(opMovRC, 22, 0, 0, randBits(32));
    emitOp(opDoutR, 22, 0, 0);
    emitOp(opDoutR, 22, 0, 0);
    emitOp(opDecR, 21, 0, 0);
    emitConst(opJnzRC, 21, 0, 0, word_t'(loopAddr));
    emitOp(opStall, 0, 0, 0);
    // Called routine
    patchHere(callSlot);
    emitConst(opMovRC, 17, 0, 0, randBits(32));
    emitOp(opDoutR, 17, 0, 0);
    emitOp(opRet, 0, 0, 0);
  endtask

  // RAM model with one-cycle read latency
  always @(posedge clk) begin
    if (readReq) ramIn <= ramImg[ramAddress[11:2]];
    if (writeReq) ramImg[ramAddress[11:2]] <= ramOut;
  end

  always @(posedge clk) cycleCount <= cycleCount + 1;

  // Dout checker
  always @(posedge clk) begin
    if (!reset && doutValid) begin
      if (doutCount >= expDout.size()) begin
        reportFailure("Unexpected extra Dout pulse from the core");
      end else begin
        if (doutCount == 0) firstDoutCycle = cycleCount;
        checkDout(doutData, expDout[doutCount]);
        checkDoutGap(cycleCount - firstDoutCycle, expStamp[doutCount] - expStamp[0]);
      end
      doutCount++;
    end
  end

  // Refetches of the Stall word
  always @(posedge clk) begin
    if (!reset && readReq && ramAddress == modelStallIp) stallFetches++;
  end

  initial begin
    wait (modelReady);
    #(longint'(watchCycles) * 10);
    reportFailure("Timeout, the core did not reach the final Stall in time");
  end

  initial begin
    int steps;
    reset = 1'b1;
    ramIn = '0;
    buildProgram();
    for (int i = 0; i < 1024; i++) begin
      ramImg[i]   = prog[i];
      modelMem[i] = prog[i];
    end
    steps = runModel(5000);
    watchCycles = steps * 10 + 100;     // Worst case 10 per instruction
    modelReady = 1'b1;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    while (stallFetches < 2) @(posedge clk);
    if (doutCount != expDout.size()) begin
      reportFailure($sformatf("Core gave %0d Dout pulses but %0d were expected",
                              doutCount, expDout.size()));
    end else begin
      for (int i = 0; i < 1024; i++) checkRamWord(i, ramImg[i], modelMem[i]);
      $display("Test OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- phaethon.f
+incdir+design
+incdir+tb
design/phaethonPkg.sv
design/instrDecode.sv
design/executeUnit.sv
design/regWriteBack.sv
design/coreSequencer.sv
design/phaethonCore.sv
tb/phaethonTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the phaethonCore testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module phaethonTb \
  -f phaethon.f -o phaethonSim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/phaethonSim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

echo "Simulation finished cleanly"
exit 0
